// ==== design/z80_config.svh ====
`ifndef Z80_CONFIG_SVH
`define Z80_CONFIG_SVH

// Memory port widths
`define Z80_ADDR_W 16
`define Z80_DATA_W 8

// Longest kept instruction is the ED form of LD dd,(nn)
`define Z80_MAX_INSN_BYTES 4

// Only prefix still decoded
`define Z80_PREFIX_ED 8'hED

// High bits of a register select that mark a pair
`define REG_SET_DD 2'b10
`define REG_SET_QQ 2'b11

`define REG_A 4'd7
`define DD_REG_HL 4'd10
`define DD_REG_SP 4'd11

`endif

// ==== design/z80_pkg.sv ====
`include "z80_config.svh"

package z80_pkg;

    typedef logic [`Z80_DATA_W-1:0] byte_t;
    typedef logic [`Z80_ADDR_W-1:0] word_t;

    // First byte of the instruction sits in the lowest byte
    typedef logic [8*`Z80_MAX_INSN_BYTES-1:0] insn_t;
    typedef logic [$clog2(`Z80_MAX_INSN_BYTES+1)-1:0] insn_len_t;

    // 0-7 byte registers (6 is F), 8-11 BC DE HL SP, 12-15 BC DE HL AF
    typedef logic [3:0] reg_sel_t;

    typedef enum logic [3:0] {
        NEED_MORE_BYTES,
        NOP,
        LD_REG_REG,
        LD_REG_N,
        LD_DD_NN,
        LD_A_IND_NN,
        LD_IND_NN_A,
        LD_IND_HL_REG,
        LD_IND_HL_N,
        LD_DD_IND_NN,
        LD_IND_NN_DD,
        LD_SP_HL,
        PUSH_QQ,
        POP_QQ,
        OTHER
    } insn_group_t;

    typedef enum logic [1:0] {
        STEP0,
        STEP1,
        STEP2
    } seq_step_t;

endpackage

// ==== design/instr_decoder.sv ====
`include "z80_config.svh"

module instr_decoder (
    input  z80_pkg::insn_t      insn,
    input  z80_pkg::insn_len_t  insn_len,
    output z80_pkg::insn_group_t group,
    output z80_pkg::insn_len_t  decoded_len
);
    import z80_pkg::*;

    byte_t op;
    byte_t ed_op;

    assign op = insn[7:0];
    assign ed_op = insn[15:8];

    always_comb begin
        group = OTHER;
        decoded_len = insn_len_t'(1);

        if (op == `Z80_PREFIX_ED) begin
            decoded_len = insn_len_t'(2);
            if (insn_len < insn_len_t'(2)) begin
                // The second byte picks the operation
                group = NEED_MORE_BYTES;
            end else if (ed_op[7:6] == 2'b01 && ed_op[2:0] == 3'b011) begin
                decoded_len = insn_len_t'(4);
                group = ed_op[3] ? LD_DD_IND_NN : LD_IND_NN_DD;
            end
        end else if (op == 8'h00) begin
            group = NOP;
        end else if (op[7:6] == 2'b01) begin
            // 76 is HALT, and LD r,(HL) is not supported here
            if (op[5:3] == 3'd6 && op[2:0] == 3'd6) begin
                group = OTHER;
            end else if (op[5:3] == 3'd6) begin
                group = LD_IND_HL_REG;
            end else if (op[2:0] == 3'd6) begin
                group = OTHER;
            end else begin
                group = LD_REG_REG;
            end
        end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin
            decoded_len = insn_len_t'(2);
            group = (op[5:3] == 3'd6) ? LD_IND_HL_N : LD_REG_N;
        end else if (op[7:6] == 2'b00 && op[3:0] == 4'b0001) begin
            decoded_len = insn_len_t'(3);
            group = LD_DD_NN;
        end else if (op == 8'h3A) begin
            decoded_len = insn_len_t'(3);
            group = LD_A_IND_NN;
        end else if (op == 8'h32) begin
            decoded_len = insn_len_t'(3);
            group = LD_IND_NN_A;
        end else if (op == 8'hF9) begin
            group = LD_SP_HL;
        end else if (op[7:6] == 2'b11 && op[3:0] == 4'b0101) begin
            group = PUSH_QQ;
        end else if (op[7:6] == 2'b11 && op[3:0] == 4'b0001) begin
            group = POP_QQ;
        end
    end

    // The sequencer always offers at least the byte arriving now
    always_comb begin
        assert final (insn_len != '0)
            else $error("decoder consulted with no instruction bytes");
    end

endmodule

// ==== design/register_file.sv ====
`include "z80_config.svh"

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  z80_pkg::reg_sel_t rd1_sel,
    input  z80_pkg::reg_sel_t rd2_sel,
    output z80_pkg::word_t    rd1_data,
    output z80_pkg::word_t    rd2_data,
    input  logic              wr_en,
    input  z80_pkg::reg_sel_t wr_sel,
    input  z80_pkg::word_t    wr_data
);
    import z80_pkg::*;

    // Byte registers B C D E H L F A in r encoding order
    byte_t regs [8];
    word_t sp;

    function automatic logic [2:0] hi_idx(input reg_sel_t sel);
        if (sel[3:2] == `REG_SET_QQ && sel[1:0] == 2'd3) begin
            return 3'd7;
        end
        return {sel[1:0], 1'b0};
    endfunction

    function automatic logic [2:0] lo_idx(input reg_sel_t sel);
        if (sel[3:2] == `REG_SET_QQ && sel[1:0] == 2'd3) begin
            return 3'd6;
        end
        return {sel[1:0], 1'b1};
    endfunction

    function automatic word_t read_sel(input reg_sel_t sel);
        if (!sel[3]) begin
            return {byte_t'(0), regs[sel[2:0]]};
        end
        if (sel == `DD_REG_SP) begin
            return sp;
        end
        return {regs[hi_idx(sel)], regs[lo_idx(sel)]};
    endfunction

    always_comb begin
        rd1_data = read_sel(rd1_sel);
        rd2_data = read_sel(rd2_sel);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            sp <= '0;
        end else if (wr_en) begin
            if (!wr_sel[3]) begin
                regs[wr_sel[2:0]] <= wr_data[7:0];
            end else if (wr_sel == `DD_REG_SP) begin
                sp <= wr_data;
            end else begin
                regs[hi_idx(wr_sel)] <= wr_data[15:8];
                regs[lo_idx(wr_sel)] <= wr_data[7:0];
            end
        end
    end

    // F only changes as half of AF because code 6 in r encoding means (HL)
    assert property (@(posedge clk) disable iff (reset) wr_en |-> wr_sel != reg_sel_t'(6))
        else $error("byte write to F");

endmodule

// ==== design/sequencer.sv ====
`include "z80_config.svh"

module sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  z80_pkg::byte_t       mem_data,
    output z80_pkg::word_t       addr,
    output logic                 read_mem,
    output logic                 write_mem,
    output z80_pkg::byte_t       write_data,
    output logic                 done,
    output z80_pkg::insn_t       insn,
    output z80_pkg::insn_len_t   insn_len,
    input  z80_pkg::insn_group_t group,
    input  z80_pkg::insn_len_t   decoded_len,
    output z80_pkg::reg_sel_t    rd1_sel,
    output z80_pkg::reg_sel_t    rd2_sel,
    input  z80_pkg::word_t       rd1_data,
    input  z80_pkg::word_t       rd2_data,
    output logic                 wr_en,
    output z80_pkg::reg_sel_t    wr_sel,
    output z80_pkg::word_t       wr_data
);
    import z80_pkg::*;

    word_t pc;
    insn_t insn_q;
    insn_len_t count_q;
    logic insn_ready;
    word_t data_q;
    seq_step_t step;

    word_t next_pc;
    word_t next_addr;
    logic next_read;
    logic next_write;
    byte_t next_wdata;
    logic next_done;
    insn_t next_insn;
    insn_len_t next_count;
    logic next_ready;
    word_t next_data;
    seq_step_t next_step;

    word_t operand;
    logic complete;

    // Until the instruction is whole, the byte on the port joins the collected ones
    always_comb begin
        insn = insn_q;
        insn_len = count_q;
        if (!insn_ready) begin
            insn[8*count_q +: 8] = mem_data;
            insn_len = count_q + 1'b1;
        end
    end

    // ED forms carry nn after two opcode bytes
    assign operand = (insn[7:0] == `Z80_PREFIX_ED) ? insn[31:16] : insn[23:8];
    assign complete = (group != NEED_MORE_BYTES) && (decoded_len == insn_len);

    always_comb begin
        next_pc = pc;
        next_addr = addr;
        next_read = 1'b0;
        next_write = 1'b0;
        next_wdata = '0;
        next_done = 1'b0;
        next_insn = insn;
        next_count = insn_len;
        next_ready = insn_ready;
        next_data = data_q;
        next_step = step;
        rd1_sel = '0;
        rd2_sel = '0;
        wr_en = 1'b0;
        wr_sel = '0;
        wr_data = '0;

        if (!insn_ready) begin
            next_pc = pc + 1'b1;
            next_addr = pc + 1'b1;
            next_read = 1'b1;
        end

        if (complete) begin
            next_ready = 1'b1;
            case (group)
                LD_REG_REG: begin
                    rd1_sel = {1'b0, insn[2:0]};
                    wr_en = 1'b1;
                    wr_sel = {1'b0, insn[5:3]};
                    wr_data = rd1_data;
                    next_done = 1'b1;
                end
                LD_REG_N: begin
                    wr_en = 1'b1;
                    wr_sel = {1'b0, insn[5:3]};
                    wr_data = operand;
                    next_done = 1'b1;
                end
                LD_DD_NN: begin
                    wr_en = 1'b1;
                    wr_sel = {`REG_SET_DD, insn[5:4]};
                    wr_data = operand;
                    next_done = 1'b1;
                end
                LD_SP_HL: begin
                    rd1_sel = `DD_REG_HL;
                    wr_en = 1'b1;
                    wr_sel = `DD_REG_SP;
                    wr_data = rd1_data;
                    next_done = 1'b1;
                end
                LD_A_IND_NN: begin
                    if (step == STEP0) begin
                        next_addr = operand;
                        next_read = 1'b1;
                        next_step = STEP1;
                    end else begin
                        wr_en = 1'b1;
                        wr_sel = `REG_A;
                        wr_data = {byte_t'(0), mem_data};
                        next_done = 1'b1;
                    end
                end
                LD_IND_NN_A, LD_IND_HL_REG, LD_IND_HL_N: begin
                    if (step == STEP0) begin
                        rd1_sel = (group == LD_IND_NN_A) ? `REG_A : `DD_REG_HL;
                        rd2_sel = {1'b0, insn[2:0]};
                        next_read = 1'b0;
                        next_write = 1'b1;
                        next_step = STEP1;
                        case (group)
                            LD_IND_NN_A: begin
                                next_addr = operand;
                                next_wdata = rd1_data[7:0];
                            end
                            LD_IND_HL_REG: begin
                                next_addr = rd1_data;
                                next_wdata = rd2_data[7:0];
                            end
                            default: begin
                                next_addr = rd1_data;
                                next_wdata = operand[7:0];
                            end
                        endcase
                    end else begin
                        next_done = 1'b1;
                    end
                end
                LD_DD_IND_NN, POP_QQ: begin
                    rd1_sel = `DD_REG_SP;
                    case (step)
                        STEP0: begin
                            next_addr = (group == POP_QQ) ? rd1_data : operand;
                            next_read = 1'b1;
                            next_step = STEP1;
                        end
                        STEP1: begin
                            next_data = {data_q[15:8], mem_data};
                            next_addr = addr + 1'b1;
                            next_read = 1'b1;
                            next_step = STEP2;
                            if (group == POP_QQ) begin
                                wr_en = 1'b1;
                                wr_sel = `DD_REG_SP;
                                wr_data = rd1_data + word_t'(2);
                            end
                        end
                        default: begin
                            next_data = {mem_data, data_q[7:0]};
                            wr_en = 1'b1;
                            if (group == POP_QQ) begin
                                wr_sel = {`REG_SET_QQ, insn[5:4]};
                            end else begin
                                wr_sel = {`REG_SET_DD, insn[13:12]};
                            end
                            wr_data = next_data;
                            next_done = 1'b1;
                        end
                    endcase
                end
                LD_IND_NN_DD, PUSH_QQ: begin
                    rd1_sel = `DD_REG_SP;
                    if (group == PUSH_QQ) begin
                        rd2_sel = {`REG_SET_QQ, insn[5:4]};
                    end else begin
                        rd2_sel = {`REG_SET_DD, insn[13:12]};
                    end
                    case (step)
                        STEP0: begin
                            next_addr = (group == PUSH_QQ) ? rd1_data - word_t'(2) : operand;
                            next_read = 1'b0;
                            next_write = 1'b1;
                            next_wdata = rd2_data[7:0];
                            next_step = STEP1;
                        end
                        STEP1: begin
                            next_addr = addr + 1'b1;
                            next_write = 1'b1;
                            next_wdata = rd2_data[15:8];
                            next_step = STEP2;
                        end
                        default: begin
                            if (group == PUSH_QQ) begin
                                wr_en = 1'b1;
                                wr_sel = `DD_REG_SP;
                                wr_data = rd1_data - word_t'(2);
                            end
                            next_done = 1'b1;
                        end
                    endcase
                end
                default: begin
                    // NOP and anything unsupported
                    next_done = 1'b1;
                end
            endcase
        end

        if (next_done) begin
            next_addr = next_pc;
            next_read = 1'b1;
            next_write = 1'b0;
            next_insn = '0;
            next_count = '0;
            next_ready = 1'b0;
            next_step = STEP0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr <= '0;
            read_mem <= 1'b1;
            write_mem <= 1'b0;
            done <= 1'b0;
            pc <= '0;
            insn_q <= '0;
            count_q <= '0;
            insn_ready <= 1'b0;
            step <= STEP0;
        end else begin
            addr <= next_addr;
            read_mem <= next_read;
            write_mem <= next_write;
            done <= next_done;
            pc <= next_pc;
            insn_q <= next_insn;
            count_q <= next_count;
            insn_ready <= next_ready;
            step <= next_step;
        end
    end

    always_ff @(posedge clk) begin
        write_data <= next_wdata;
        data_q <= next_data;
    end

    assert property (@(posedge clk) disable iff (reset) !(read_mem && write_mem))
        else $error("read and write on the memory port together");

endmodule

// ==== design/z80_core.sv ====
module z80_core (
    input  logic           clk,
    input  logic           reset,
    input  z80_pkg::byte_t mem_data,
    output z80_pkg::word_t addr,
    output logic           read_mem,
    output logic           write_mem,
    output z80_pkg::byte_t write_data,
    output logic           done
);
    import z80_pkg::*;

    insn_t insn;
    insn_len_t insn_len;
    insn_group_t group;
    insn_len_t decoded_len;
    reg_sel_t rd1_sel;
    reg_sel_t rd2_sel;
    word_t rd1_data;
    word_t rd2_data;
    logic wr_en;
    reg_sel_t wr_sel;
    word_t wr_data;

    sequencer u_sequencer (
        .clk(clk),
        .reset(reset),
        .mem_data(mem_data),
        .addr(addr),
        .read_mem(read_mem),
        .write_mem(write_mem),
        .write_data(write_data),
        .done(done),
        .insn(insn),
        .insn_len(insn_len),
        .group(group),
        .decoded_len(decoded_len),
        .rd1_sel(rd1_sel),
        .rd2_sel(rd2_sel),
        .rd1_data(rd1_data),
        .rd2_data(rd2_data),
        .wr_en(wr_en),
        .wr_sel(wr_sel),
        .wr_data(wr_data)
    );

    instr_decoder u_decoder (
        .insn(insn),
        .insn_len(insn_len),
        .group(group),
        .decoded_len(decoded_len)
    );

    register_file u_regs (
        .clk(clk),
        .reset(reset),
        .rd1_sel(rd1_sel),
        .rd2_sel(rd2_sel),
        .rd1_data(rd1_data),
        .rd2_data(rd2_data),
        .wr_en(wr_en),
        .wr_sel(wr_sel),
        .wr_data(wr_data)
    );

endmodule

// ==== tests/tb_z80_core.sv ====
module tb_z80_core;
    timeunit 1ns;
    timeprecision 100ps;

    import z80_pkg::*;

    localparam int RESET_CYCLES = 4;

    logic clk = 1'b0;
    logic reset;
    byte_t mem_data;
    word_t addr;
    logic read_mem;
    logic write_mem;
    byte_t write_data;
    logic done;

    // Whole 64 KB address space
    byte_t mem [65536];

    logic [31:0] exp_write_addr [$];
    logic [31:0] exp_write_data [$];
    logic [31:0] exp_cycles [$];
    logic [31:0] exp_next_pc [$];
    int insn_count;
    logic loaded = 1'b0;

    z80_core u_dut (
        .clk(clk),
        .reset(reset),
        .mem_data(mem_data),
        .addr(addr),
        .read_mem(read_mem),
        .write_mem(write_mem),
        .write_data(write_data),
        .done(done)
    );

    always #4 clk = ~clk;

    assign mem_data = mem[addr];

    always @(posedge clk) begin
        if (write_mem) begin
            mem[addr] <= write_data;
        end
    end

    task automatic announce_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            announce_failure($sformatf("** Error: %s expected %0h got %0h",
                                       name, expected, actual));
            $fatal(1);
        end
    endtask

    task automatic load_input();
        int fd;
        int code;
        int shift;
        string line;
        logic [7:0] tag;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        // Every byte differs with its whole address so a stray access reads a telltale value
        for (int a = 0; a < 65536; a++) begin
            mem[a] = byte_t'(a ^ (a >> 8));
        end
        insn_count = 0;
        fd = $fopen("tests/core_input.txt", "r");
        assert (fd != 0) else begin
            announce_failure("Could not open tests/core_input.txt");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0) begin
                code = $sscanf(line, "%c %h %h %h %h", tag, f1, f2, f3, f4);
                case (tag)
                    "p": begin
                        // Bytes are listed in fetch order with the first byte in the top digits
                        for (int i = 0; i < int'(f2); i++) begin
                            shift = 8 * (int'(f2) - 1 - i);
                            mem[word_t'(f1 + 32'(i))] = f3[shift +: 8];
                        end
                        exp_cycles.push_back(f4);
                        exp_next_pc.push_back(32'(word_t'(f1 + f2)));
                    end
                    "d": mem[word_t'(f1)] = f2[7:0];
                    "w": begin
                        exp_write_addr.push_back(f1);
                        exp_write_data.push_back(f2);
                    end
                    "n": insn_count = int'(f1);
                    default: ;
                endcase
            end
        end
        $fclose(fd);
        assert (insn_count == exp_cycles.size() && insn_count > 0) else begin
            announce_failure("Instruction count in the input file does not match its list");
            $fatal(1);
        end
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (RESET_CYCLES + 20 + 8 * insn_count) @(posedge clk);
        announce_failure("Timeout: the DUT did not finish the expected instructions in time");
        $fatal(1);
    end

    initial begin : main
        int cycles;
        int last_done;
        int done_seen;
        int write_idx;
        reset = 1'b1;
        load_input();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value("addr", 32'h0, 32'(addr));
        check_value("read_mem", 32'h1, 32'(read_mem));
        check_value("write_mem", 32'h0, 32'(write_mem));
        check_value("done", 32'h0, 32'(done));
        reset = 1'b0;

        cycles = 0;
        last_done = 0;
        done_seen = 0;
        write_idx = 0;
        while (done_seen < insn_count) begin
            @(negedge clk);
            cycles++;
            assert (!(read_mem && write_mem)) else begin
                announce_failure("read_mem and write_mem were high in the same cycle");
                $fatal(1);
            end
            if (write_mem) begin
                assert (write_idx < exp_write_addr.size()) else begin
                    announce_failure($sformatf("Unexpected memory write at address %0h", addr));
                    $fatal(1);
                end
                check_value("addr", exp_write_addr[write_idx], 32'(addr));
                check_value("write_data", exp_write_data[write_idx], 32'(write_data));
                write_idx++;
            end
            if (done) begin
                check_value("done interval", exp_cycles[done_seen], 32'(cycles - last_done));
                // The next opcode fetch is on the port in the done cycle
                check_value("read_mem", 32'h1, 32'(read_mem));
                check_value("addr", exp_next_pc[done_seen], 32'(addr));
                last_done = cycles;
                done_seen++;
            end
        end

        assert (write_idx == exp_write_addr.size()) else begin
            announce_failure($sformatf("Only %0d of %0d expected memory writes were seen",
                                       write_idx, exp_write_addr.size()));
            $fatal(1);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tests/core_input.txt ====
# p addr len bytes cycles: instruction at addr, bytes in fetch order, cycles to its done
# d addr byte: initial data   w addr byte: expected write, in order   n count   (all hex)
p 0000 2 0612 2
p 0002 2 0E34 2
p 0004 3 214000 3
p 0007 1 70 2
p 0008 1 79 1
p 0009 3 324100 4
p 000C 3 310001 3
p 000F 3 3A5000 4
p 0012 2 365C 3
p 0014 4 ED5B5200 6
p 0018 4 ED534200 6
p 001C 1 C5 3
p 001D 1 F5 3
p 001E 1 D1 3
p 001F 1 E1 3
p 0020 4 ED534400 6
p 0024 1 77 2
p 0025 1 F9 1
p 0026 1 7D 1
p 0027 1 C5 3
p 0028 4 ED734600 6
p 002C 3 324800 4
p 002F 1 76 1
p 0030 1 00 1
d 0050 A5
d 0052 EF
d 0053 BE
w 0040 12
w 0041 34
w 0040 5C
w 0042 EF
w 0043 BE
w 00FE 34
w 00FF 12
w 00FC 00
w 00FD A5
w 0044 00
w 0045 A5
w 1234 A5
w 1232 34
w 1233 12
w 0046 32
w 0047 12
w 0048 34
n 18

// ==== src.f ====
+incdir+design
design/z80_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/sequencer.sv
design/z80_core.sv
tests/tb_z80_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module tb_z80_core

output=$(./obj_dir/Vtb_z80_core) || true
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
exit 1
